// ==== dmem_lsu.f ====
src/lsu_types_pkg.sv
src/dmem_cfg_pkg.sv
src/lsu_decode.sv
src/byte_bank.sv
src/load_format.sv
src/dmem_lsu.sv
tests/tb_dmem_lsu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the dmem_lsu testbench with Verilator and run it; exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_dmem_lsu \
    -f dmem_lsu.f \
    --Mdir obj_dir -o tb_dmem_lsu_sim \
    && ./obj_dir/tb_dmem_lsu_sim \
    || { echo "Build or simulation failed" >&2; exit 1; }

// ==== src/byte_bank.sv ====
// Byte-wide bank with synchronous write and registered read
`default_nettype none

module byte_bank (
    input  wire logic                    clk,
    input  wire logic                    we,       // Write this lane
    input  wire logic                    re,       // Read this lane
    input  wire dmem_cfg_pkg::bank_idx_t idx,      // Word index
    input  wire lsu_types_pkg::byte_t    wdata,
    output      lsu_types_pkg::byte_t    rdata     // Held while re is low
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    lsu_types_pkg::byte_t mem [dmem_cfg_pkg::BANK_DEPTH];  // Contents not cleared

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;                   // Visible to a read next edge
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // Decoder never raises we and re together, one op per cycle
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[idx];                   // Old value kept otherwise
        end
    end

endmodule : byte_bank

`default_nettype wire

// ==== src/dmem_cfg_pkg.sv ====
// Data memory geometry: lane count, bank depth, index width, bank index type
`default_nettype none

package dmem_cfg_pkg;

    //////////////////////////////////////////////////
    // Bank geometry
    //////////////////////////////////////////////////

    localparam int NUM_LANES  = 4;      // Byte lanes per word
    localparam int BANK_DEPTH = 256;    // Words per bank
    localparam int BANK_AW    = 8;      // log2(BANK_DEPTH)

    // Word index shared by every lane
    // Taken from address[BANK_AW+1:2], upper bits dropped
    typedef logic [BANK_AW-1:0] bank_idx_t;

endpackage : dmem_cfg_pkg

`default_nettype wire

// ==== src/dmem_lsu.sv ====
// Top level: access decoder, four byte banks, load formatter
`default_nettype none

module dmem_lsu (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // Request, one per cycle, no ready
    input  wire logic                   req_valid,
    input  wire lsu_types_pkg::lsu_op_t req_op,
    input  wire lsu_types_pkg::word_t   req_base,
    input  wire lsu_types_pkg::word_t   req_offset,
    input  wire lsu_types_pkg::word_t   req_wdata,
    // Response, two cycles later
    output      logic                   rsp_valid,
    output      lsu_types_pkg::word_t   rsp_data,
    output      logic                   rsp_rd_we,
    output      logic                   rsp_fault
);

    //////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////

    dmem_cfg_pkg::bank_idx_t                            bank_idx;
    logic                                               bank_re;
    logic [dmem_cfg_pkg::NUM_LANES-1:0]                 lane_we;
    lsu_types_pkg::byte_t [dmem_cfg_pkg::NUM_LANES-1:0] lane_wdata;
    lsu_types_pkg::byte_t [dmem_cfg_pkg::NUM_LANES-1:0] lane_rdata;

    logic                   s1_valid;
    lsu_types_pkg::lsu_op_t s1_op;
    logic [1:0]             s1_byte_off;
    logic                   s1_fault;
    lsu_types_pkg::word_t   s1_wdata;

    //////////////////////////////////////////////////
    // Stage 0: decode
    //////////////////////////////////////////////////

    lsu_decode i_lsu_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_base    (req_base),
        .req_offset  (req_offset),
        .req_wdata   (req_wdata),
        .bank_idx    (bank_idx),
        .bank_re     (bank_re),
        .lane_we     (lane_we),
        .lane_wdata  (lane_wdata),
        .s1_valid    (s1_valid),
        .s1_op       (s1_op),
        .s1_byte_off (s1_byte_off),
        .s1_fault    (s1_fault),
        .s1_wdata    (s1_wdata)
    );

    //////////////////////////////////////////////////
    // Byte banks
    //////////////////////////////////////////////////

    for (genvar k = 0; k < dmem_cfg_pkg::NUM_LANES; k++) begin : g_lane
        byte_bank i_byte_bank (
            .clk   (clk),
            .we    (lane_we[k]),
            .re    (bank_re),             // All lanes read together
            .idx   (bank_idx),
            .wdata (lane_wdata[k]),
            .rdata (lane_rdata[k])
        );
    end

    //////////////////////////////////////////////////
    // Stage 1: format
    //////////////////////////////////////////////////

    load_format i_load_format (
        .clk         (clk),
        .rst_n       (rst_n),
        .s1_valid    (s1_valid),
        .s1_op       (s1_op),
        .s1_byte_off (s1_byte_off),
        .s1_fault    (s1_fault),
        .s1_wdata    (s1_wdata),
        .lane_rdata  (lane_rdata),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .rsp_rd_we   (rsp_rd_we),
        .rsp_fault   (rsp_fault)
    );

endmodule : dmem_lsu

`default_nettype wire

// ==== src/load_format.sv ====
// Load formatter: lane select, sign or zero extension, store echo, response registers
`default_nettype none

module load_format (
    input  wire logic                                          clk,
    input  wire logic                                          rst_n,
    // Stage-1 tag
    input  wire logic                                          s1_valid,
    input  wire lsu_types_pkg::lsu_op_t                        s1_op,
    input  wire logic [1:0]                                    s1_byte_off,
    input  wire logic                                          s1_fault,
    input  wire lsu_types_pkg::word_t                          s1_wdata,
    // Bank outputs
    input  wire lsu_types_pkg::byte_t [dmem_cfg_pkg::NUM_LANES-1:0] lane_rdata,
    // Response
    output      logic                                          rsp_valid,
    output      lsu_types_pkg::word_t                          rsp_data,
    output      logic                                          rsp_rd_we,
    output      logic                                          rsp_fault
);

    lsu_types_pkg::word_t rd_word;     // Four lanes as one word
    lsu_types_pkg::byte_t sel_byte;    // Addressed byte
    lsu_types_pkg::half_t sel_half;    // Addressed half
    lsu_types_pkg::word_t ext_data;    // Extended load or store echo
    logic                 is_load;
    lsu_types_pkg::word_t next_data;

    //////////////////////////////////////////////////
    // Lane selection
    //////////////////////////////////////////////////

    assign rd_word  = lane_rdata;                  // Lane 0 in bits 7:0
    assign sel_byte = lane_rdata[s1_byte_off];
    assign sel_half = s1_byte_off[1] ? rd_word[31:16] : rd_word[15:0];  // Even offsets only

    //////////////////////////////////////////////////
    // Extension
    //////////////////////////////////////////////////

    always_comb begin
        case (s1_op)
            lsu_types_pkg::LB:  ext_data = {{24{sel_byte[7]}}, sel_byte};   // Sign
            lsu_types_pkg::LBU: ext_data = {24'h0, sel_byte};               // Zero
            lsu_types_pkg::LH:  ext_data = {{16{sel_half[15]}}, sel_half};  // Sign
            lsu_types_pkg::LHU: ext_data = {16'h0, sel_half};               // Zero
            lsu_types_pkg::LW:  ext_data = rd_word;
            default:            ext_data = s1_wdata;   // Stores echo their data
        endcase
    end

    assign is_load   = lsu_types_pkg::op_is_load(s1_op);
    assign next_data = s1_fault ? '0 : ext_data;   // Fault returns zero

    //////////////////////////////////////////////////
    // Response registers
    //////////////////////////////////////////////////

    // Control flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_rd_we <= 1'b0;
            rsp_fault <= 1'b0;
        end else begin
            rsp_valid <= s1_valid;
            rsp_rd_we <= s1_valid & is_load & ~s1_fault;  // Clean loads only
            rsp_fault <= s1_valid & s1_fault;
        end
    end

    // Data word
    always_ff @(posedge clk) begin
        rsp_data <= next_data;
    end

endmodule : load_format

`default_nettype wire

// ==== src/lsu_decode.sv ====
// Access decoder: address add, alignment check, lane enables, store steering, stage-1 tag
`default_nettype none

module lsu_decode (
    input  wire logic                                          clk,
    input  wire logic                                          rst_n,
    // Request side
    input  wire logic                                          req_valid,
    input  wire lsu_types_pkg::lsu_op_t                        req_op,
    input  wire lsu_types_pkg::word_t                          req_base,
    input  wire lsu_types_pkg::word_t                          req_offset,
    input  wire lsu_types_pkg::word_t                          req_wdata,
    // Bank side
    output      dmem_cfg_pkg::bank_idx_t                       bank_idx,
    output      logic                                          bank_re,
    output      logic [dmem_cfg_pkg::NUM_LANES-1:0]            lane_we,
    output      lsu_types_pkg::byte_t [dmem_cfg_pkg::NUM_LANES-1:0] lane_wdata,
    // Stage-1 tag to the formatter
    output      logic                                          s1_valid,
    output      lsu_types_pkg::lsu_op_t                        s1_op,
    output      logic [1:0]                                    s1_byte_off,
    output      logic                                          s1_fault,
    output      lsu_types_pkg::word_t                          s1_wdata
);

    lsu_types_pkg::word_t               addr;         // Effective address
    logic [1:0]                         byte_off;     // Lane of the first byte
    logic                               is_load;
    logic                               is_store;
    logic                               size_b;       // Byte access
    logic                               size_h;       // Half access
    logic                               size_w;       // Word access
    logic                               misaligned;
    logic [dmem_cfg_pkg::NUM_LANES-1:0] size_mask;    // Lanes touched, before validity
    lsu_types_pkg::word_t               steered;      // Store data replicated to lanes

    //////////////////////////////////////////////////
    // Address generation
    //////////////////////////////////////////////////

    assign addr     = req_base + req_offset;          // Base plus offset, wraps
    assign byte_off = addr[1:0];
    assign bank_idx = addr[dmem_cfg_pkg::BANK_AW+1:2]; // Upper bits ignored

    //////////////////////////////////////////////////
    // Operation class and size
    //////////////////////////////////////////////////

    assign is_load  = lsu_types_pkg::op_is_load(req_op);
    assign is_store = ~is_load;

    always_comb begin
        size_b = 1'b0;
        size_h = 1'b0;
        size_w = 1'b0;
        case (req_op)
            lsu_types_pkg::LB,
            lsu_types_pkg::LBU,
            lsu_types_pkg::SB:  size_b = 1'b1;    // One lane
            lsu_types_pkg::LH,
            lsu_types_pkg::LHU,
            lsu_types_pkg::SH:  size_h = 1'b1;    // Two lanes
            default:            size_w = 1'b1;    // LW, SW
        endcase
    end

    // Half must be even, word must be on a word boundary
    assign misaligned = (size_h & byte_off[0]) |
                        (size_w & (byte_off != 2'b00));

    //////////////////////////////////////////////////
    // Write mask and store data
    //////////////////////////////////////////////////

    always_comb begin
        if (size_b) begin
            size_mask = 4'b0001 << byte_off;              // Lane addr[1:0]
            steered   = {4{req_wdata[7:0]}};              // Byte on every lane
        end else if (size_h) begin
            size_mask = 4'b0011 << {byte_off[1], 1'b0};   // Lanes 0-1 or 2-3
            steered   = {2{req_wdata[15:0]}};             // Half on both pairs
        end else begin
            size_mask = 4'b1111;
            steered   = req_wdata;                        // Word as is
        end
    end

    // Faulted or idle cycles touch no lane
    assign lane_we    = (req_valid & is_store & ~misaligned) ? size_mask : '0;
    assign lane_wdata = steered;                          // Lane k gets bits 8k+7:8k
    assign bank_re    = req_valid & is_load & ~misaligned;

    //////////////////////////////////////////////////
    // Stage-1 tag
    //////////////////////////////////////////////////

    // Control bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_fault <= 1'b0;
        end else begin
            s1_valid <= req_valid;
            s1_fault <= req_valid & misaligned;   // Only meaningful with valid
        end
    end

    // Payload travelling beside the bank read
    always_ff @(posedge clk) begin
        s1_op       <= req_op;
        s1_byte_off <= byte_off;
        s1_wdata    <= req_wdata;                 // Unsteered, echoed on stores
    end

endmodule : lsu_decode

`default_nettype wire

// ==== src/lsu_types_pkg.sv ====
// LSU operation enum, word, half and byte types, load test function, pipeline latency
`default_nettype none

package lsu_types_pkg;

    //////////////////////////////////////////////////
    // Data widths
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;    // Address or data word
    typedef logic [15:0] half_t;    // Half word for LH/LHU/SH
    typedef logic [7:0]  byte_t;    // One bank lane

    //////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////

    // Loads first, stores after
    typedef enum logic [2:0] {
        LB  = 3'd0,                 // Load byte, sign extended
        LBU = 3'd1,                 // Load byte, zero extended
        LH  = 3'd2,                 // Load half, sign extended
        LHU = 3'd3,                 // Load half, zero extended
        LW  = 3'd4,                 // Load word
        SB  = 3'd5,                 // Store byte
        SH  = 3'd6,                 // Store half
        SW  = 3'd7                  // Store word
    } lsu_op_t;

    // Cycles from request edge to response
    localparam int LSU_LATENCY = 2;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // High for any load, low for the three stores
    function automatic logic op_is_load(input lsu_op_t op);
        logic load;
        case (op)
            LB, LBU, LH, LHU, LW: load = 1'b1;
            default:              load = 1'b0;  // SB, SH, SW
        endcase
        return load;
    endfunction

endpackage : lsu_types_pkg

`default_nettype wire

// ==== tests/tb_dmem_lsu.sv ====
// Directed testbench for dmem_lsu: clock, reset, reference memory, response monitor, tests
`default_nettype none

module tb_dmem_lsu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_BITS   = dmem_cfg_pkg::BANK_AW + 2;   // Byte address bits kept
    localparam int MEM_BYTES   = dmem_cfg_pkg::NUM_LANES * dmem_cfg_pkg::BANK_DEPTH;
    localparam int RSP_TIMEOUT = 10;                          // Cycles allowed to drain

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   req_valid;
    lsu_types_pkg::lsu_op_t req_op;
    lsu_types_pkg::word_t   req_base;
    lsu_types_pkg::word_t   req_offset;
    lsu_types_pkg::word_t   req_wdata;
    logic                   rsp_valid;
    lsu_types_pkg::word_t   rsp_data;
    logic                   rsp_rd_we;
    logic                   rsp_fault;

    lsu_types_pkg::byte_t   ref_mem [MEM_BYTES];   // Byte addressed model
    lsu_types_pkg::word_t   exp_data_q [$];        // Oldest response first
    logic                   exp_rd_we_q [$];
    logic                   exp_fault_q [$];
    int                     exp_edge_q [$];        // Edge count when rsp_valid is due
    int                     edge_cnt = 0;
    int                     seed = 32'h283b;

    dmem_lsu i_dmem_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_wdata  (req_wdata),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_rd_we  (rsp_rd_we),
        .rsp_fault  (rsp_fault)
    );

    //////////////////////////////////////////////////
    // Clock and edge count
    //////////////////////////////////////////////////

    always #50 clk = ~clk;                          // 100 ns period

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;                   // Read before update by everyone
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    //////////////////////////////////////////////////
    // Request driver and reference model
    //////////////////////////////////////////////////

    task automatic issue(input lsu_types_pkg::lsu_op_t op, input lsu_types_pkg::word_t base,
                         input lsu_types_pkg::word_t offset, input lsu_types_pkg::word_t wdata);
        lsu_types_pkg::word_t addr;
        lsu_types_pkg::word_t load_val;
        lsu_types_pkg::word_t exp_data;
        logic [ADDR_BITS-1:0] byte_addr;
        logic [ADDR_BITS-1:0] lane_addr;
        logic [1:0]           size_m1;              // Access bytes minus one
        logic                 load;
        logic                 fault;
        int                   i;

        @(posedge clk);
        req_valid  <= 1'b1;
        req_op     <= op;
        req_base   <= base;
        req_offset <= offset;
        req_wdata  <= wdata;

        addr      = base + offset;
        byte_addr = addr[ADDR_BITS-1:0];            // Upper bits ignored
        case (op)
            lsu_types_pkg::LB, lsu_types_pkg::LBU, lsu_types_pkg::SB: size_m1 = 2'd0;
            lsu_types_pkg::LH, lsu_types_pkg::LHU, lsu_types_pkg::SH: size_m1 = 2'd1;
            default:                                                  size_m1 = 2'd3;
        endcase
        load  = (op != lsu_types_pkg::SB) && (op != lsu_types_pkg::SH) &&
                (op != lsu_types_pkg::SW);
        fault = (byte_addr[1:0] & size_m1) != 2'b00;   // Natural alignment rule

        load_val = '0;
        if (!fault) begin
            for (i = 0; i <= int'(size_m1); i++) begin
                lane_addr = byte_addr + ADDR_BITS'(i);
                if (load) begin
                    load_val = load_val |
                               (lsu_types_pkg::word_t'(ref_mem[lane_addr]) << (8 * i));
                end else begin
                    ref_mem[lane_addr] = lsu_types_pkg::byte_t'(wdata >> (8 * i));
                end
            end
        end
        if (op == lsu_types_pkg::LB) begin
            load_val = {{24{load_val[7]}}, load_val[7:0]};
        end else if (op == lsu_types_pkg::LH) begin
            load_val = {{16{load_val[15]}}, load_val[15:0]};
        end

        if (fault) begin
            exp_data = '0;
        end else if (load) begin
            exp_data = load_val;
        end else begin
            exp_data = wdata;                       // Stores echo raw data
        end
        exp_data_q.push_back(exp_data);
        exp_rd_we_q.push_back(load && !fault);
        exp_fault_q.push_back(fault);
        exp_edge_q.push_back(edge_cnt + 1 + lsu_types_pkg::LSU_LATENCY);
    endtask

    task automatic release_bus();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;

        waited = 0;
        while (exp_data_q.size() != 0 && waited < RSP_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            stop_run($sformatf("Timeout: no response arrived within %0d cycles", RSP_TIMEOUT));
        end
    endtask

    //////////////////////////////////////////////////
    // Response monitor
    //////////////////////////////////////////////////

    always @(posedge clk) begin : check_rsp
        lsu_types_pkg::word_t e_data;
        logic                 e_rd_we;
        logic                 e_fault;
        int                   e_edge;

        if (rsp_valid) begin
            assert (exp_data_q.size() != 0)
                else stop_run($sformatf("Fail at %0d ns: response with no request", $time));
            e_data  = exp_data_q.pop_front();
            e_rd_we = exp_rd_we_q.pop_front();
            e_fault = exp_fault_q.pop_front();
            e_edge  = exp_edge_q.pop_front();
            assert (edge_cnt == e_edge)
                else stop_run($sformatf("Fail at %0d ns: response at edge %0d, expected %0d",
                                        $time, edge_cnt, e_edge));
            assert (rsp_data == e_data)
                else stop_run($sformatf("Fail at %0d ns: rsp_data %08h, expected %08h",
                                        $time, rsp_data, e_data));
            assert (rsp_rd_we == e_rd_we)
                else stop_run($sformatf("Fail at %0d ns: rsp_rd_we %0b, expected %0b",
                                        $time, rsp_rd_we, e_rd_we));
            assert (rsp_fault == e_fault)
                else stop_run($sformatf("Fail at %0d ns: rsp_fault %0b, expected %0b",
                                        $time, rsp_fault, e_fault));
        end
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        int n;

        for (n = 0; n < 6; n++) begin                // Bus idle throughout
            @(posedge clk);
            assert (rsp_valid == 1'b0 && rsp_rd_we == 1'b0 && rsp_fault == 1'b0)
                else stop_run($sformatf("Fail at %0d ns: response flags high while idle",
                                        $time));
        end
    endtask

    task automatic test_word_roundtrip();
        lsu_types_pkg::word_t r;

        r = $random(seed);
        issue(lsu_types_pkg::SW, 32'h0000_0000, 32'h0000_0010, r);
        issue(lsu_types_pkg::LW, 32'h0000_0000, 32'h0000_0010, 32'h0);
        r = $random(seed);
        issue(lsu_types_pkg::SW, 32'h0000_0100, 32'hffff_fffc, r);   // Negative offset
        issue(lsu_types_pkg::LW, 32'h0000_00f0, 32'h0000_000c, 32'h0);
        r = $random(seed);
        issue(lsu_types_pkg::SW, 32'h8000_0040, 32'h0000_0020, r);   // High bits dropped
        issue(lsu_types_pkg::LW, 32'h0000_0060, 32'h0000_0000, 32'h0);
        r = $random(seed);
        issue(lsu_types_pkg::SW, 32'h0000_03f0, 32'h0000_000c, r);   // Last word
        issue(lsu_types_pkg::LW, 32'h0000_03fc, 32'h0000_0000, 32'h0);
        release_bus();
        wait_drain();
    endtask

    task automatic test_sub_word();
        lsu_types_pkg::word_t r;
        lsu_types_pkg::byte_t bval;
        lsu_types_pkg::half_t hval;
        logic [1:0]           off;
        int                   k;

        for (k = 0; k < 8; k++) begin                // Every lane, both sign cases
            r    = $random(seed);
            off  = k[1:0];
            bval = k[2] ? 8'hb7 : 8'h4e;
            issue(lsu_types_pkg::SW, 32'h40, 32'h0, 32'h1357_9bdf);
            issue(lsu_types_pkg::SB, 32'h40, {30'h0, off}, {r[31:8], bval});
            issue(lsu_types_pkg::LB, 32'h40, {30'h0, off}, 32'h0);
            issue(lsu_types_pkg::LBU, 32'h40, {30'h0, off}, 32'h0);
            issue(lsu_types_pkg::LW, 32'h40, 32'h0, 32'h0);          // Neighbours kept
        end
        for (k = 0; k < 4; k++) begin                // Both halves, both sign cases
            r    = $random(seed);
            off  = {k[0], 1'b0};
            hval = k[1] ? 16'h8a3c : 16'h71e5;
            issue(lsu_types_pkg::SW, 32'h3c, 32'h4, 32'h2468_ace1);
            issue(lsu_types_pkg::SH, 32'h3c, 32'h4 + {30'h0, off}, {r[31:16], hval});
            issue(lsu_types_pkg::LH, 32'h3c, 32'h4 + {30'h0, off}, 32'h0);
            issue(lsu_types_pkg::LHU, 32'h3c, 32'h4 + {30'h0, off}, 32'h0);
            issue(lsu_types_pkg::LW, 32'h3c, 32'h4, 32'h0);
        end
        release_bus();
        wait_drain();
    endtask

    task automatic test_misaligned();
        lsu_types_pkg::word_t r;
        int                   k;

        issue(lsu_types_pkg::SW, 32'h80, 32'h0, 32'hc0de_5a17);
        issue(lsu_types_pkg::SW, 32'h84, 32'h0, 32'h2468_ace0);     // Guard word above
        for (k = 1; k < 4; k++) begin
            r = $random(seed);
            issue(lsu_types_pkg::SW, 32'h80, lsu_types_pkg::word_t'(k), r);
            issue(lsu_types_pkg::LW, 32'h80, lsu_types_pkg::word_t'(k), r);
            if (k != 2) begin                        // Odd offsets for halves
                issue(lsu_types_pkg::SH, 32'h80, lsu_types_pkg::word_t'(k), r);
                issue(lsu_types_pkg::LH, 32'h80, lsu_types_pkg::word_t'(k), r);
                issue(lsu_types_pkg::LHU, 32'h80, lsu_types_pkg::word_t'(k), r);
            end
        end
        issue(lsu_types_pkg::LW, 32'h80, 32'h0, 32'h0);              // Memory unchanged
        issue(lsu_types_pkg::LW, 32'h84, 32'h0, 32'h0);
        release_bus();
        wait_drain();
    endtask

    task automatic test_back_to_back();
        lsu_types_pkg::word_t   r;
        lsu_types_pkg::word_t   base;
        lsu_types_pkg::word_t   target;
        lsu_types_pkg::lsu_op_t op;
        logic [1:0]             off;
        int                     n;

        for (n = 0; n < 8; n++) begin                // Known window at 0x200
            issue(lsu_types_pkg::SW, 32'h200, lsu_types_pkg::word_t'(n * 4), $random(seed));
        end
        issue(lsu_types_pkg::SW, 32'h204, 32'h0, $random(seed));
        issue(lsu_types_pkg::LW, 32'h200, 32'h4, 32'h0);             // Same word next cycle
        for (n = 0; n < 64; n++) begin
            r  = $random(seed);
            op = lsu_types_pkg::lsu_op_t'(r[2:0]);
            case (op)
                lsu_types_pkg::LB, lsu_types_pkg::LBU, lsu_types_pkg::SB: off = r[4:3];
                lsu_types_pkg::LH, lsu_types_pkg::LHU, lsu_types_pkg::SH: off = {r[4], 1'b0};
                default:                                                  off = 2'b00;
            endcase
            target = {r[30:9], 5'b10000, r[7:5], off};                // Random high bits
            base   = $random(seed);
            issue(op, base, target - base, $random(seed));
        end
        release_bus();
        wait_drain();
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_op     = lsu_types_pkg::LB;
        req_base   = '0;
        req_offset = '0;
        req_wdata  = '0;
        repeat (2) @(posedge clk);                   // Reset for two cycles
        rst_n <= 1'b1;

        test_reset();
        test_word_roundtrip();
        test_sub_word();
        test_misaligned();
        test_back_to_back();

        $display("All checks passed");
        $finish;
    end

endmodule : tb_dmem_lsu

`default_nettype wire
